//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    // ====================
    // Opcodes
    // ====================

    typedef logic [5:0] opcodeT;

    localparam opcodeT OpSta   = 6'h20; // Store Rx at direct address
    localparam opcodeT OpLddrl = 6'h21; // Two bytes into DR
    localparam opcodeT OpLddrh = 6'h22; // Four bytes into DR
    localparam opcodeT OpStdr  = 6'h23; // DR to a register
    localparam opcodeT OpStrim = 6'h24; // Store Rx at AR plus offset

    // ====================
    // Register codes
    // ====================

    // STDR destination field
    localparam logic [2:0] DestPc    = 3'd0;
    localparam logic [2:0] DestSp    = 3'd1;
    localparam logic [2:0] DestAr    = 3'd2;
    localparam logic [2:0] DestArAlt = 3'd3; // Second code for AR
    localparam logic [2:0] DestR1    = 3'd4;
    localparam logic [2:0] DestR2    = 3'd5;
    localparam logic [2:0] DestR3    = 3'd6;
    localparam logic [2:0] DestR4    = 3'd7;

    // ====================
    // Instruction word
    // ====================

    typedef struct packed {
        opcodeT     opcode;
        logic [1:0] regSel;  // Source register, R1..R4
        logic [7:0] address; // Direct address, or offset for STRIM
    } addressFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] destReg;
        logic [2:0] srcReg1;
        logic [2:0] srcReg2;
        logic       spare;
    } registerFormT;

    // Same 16 bits, read in the format the opcode calls for
    typedef union packed {
        addressFormT  addressForm;
        registerFormT registerForm;
    } instructionT;

endpackage

`default_nettype wire

//--- rtl/datapathPkg.sv
`default_nettype none

package datapathPkg;

    // ====================
    // Widths
    // ====================

    localparam int AddrWidth       = 8;
    localparam int ByteWidth       = 8;
    localparam int WordWidth       = 32;
    localparam int GeneralRegCount = 4;
    localparam int StepCount       = 9;

    // One-hot timing steps
    typedef logic [StepCount-1:0] stepT;

    localparam stepT StepT0 = 9'b000000001; // Fetch low byte
    localparam stepT StepT1 = 9'b000000010; // Fetch high byte
    localparam stepT StepT2 = 9'b000000100; // Decode
    localparam stepT StepT3 = 9'b000001000;
    localparam stepT StepT4 = 9'b000010000;
    localparam stepT StepT5 = 9'b000100000;
    localparam stepT StepT6 = 9'b001000000;
    localparam stepT StepT7 = 9'b010000000;
    localparam stepT StepT8 = 9'b100000000;

    // ====================
    // Control word
    // ====================

    localparam logic [1:0] ArSrcAddress = 2'd0; // Instruction address field
    localparam logic [1:0] ArSrcSum     = 2'd1; // AR plus offset
    localparam logic [1:0] ArSrcDr      = 2'd2; // DR low byte

    localparam logic AddrFromPc = 1'b0;
    localparam logic AddrFromAr = 1'b1;

    typedef struct packed {
        logic                       pcLoad;
        logic                       arLoad;
        logic                       spLoad;
        logic                       drLoad;
        logic                       irLowLoad;
        logic                       irHighLoad;
        logic [GeneralRegCount-1:0] regLoad;     // Bit 0 is R1
        logic                       pcIncrement;
        logic                       arIncrement;
        logic [1:0]                 arLoadSource;
        logic                       drShiftIn;   // Shift DR left, else clear and load
        logic                       addressSource;
        logic [1:0]                 storeReg;
        logic [1:0]                 storeByte;
    } controlWordT;

    typedef struct packed {
        logic valid;
        logic write;
    } memCommandT;

    // ====================
    // APB
    // ====================

    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [AddrWidth-1:0] paddr;
        logic [ByteWidth-1:0] pwdata;
    } apbRequestT;

    typedef struct packed {
        logic [ByteWidth-1:0] prdata;
        logic                 pready;
    } apbResponseT;

endpackage

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic                     Clock,
    input  logic                     Reset,
    input  isaPkg::instructionT      instruction,
    input  logic                     done,
    output datapathPkg::controlWordT controlWord,
    output datapathPkg::memCommandT  memCommand
);
    import isaPkg::*;
    import datapathPkg::*;

    stepT        step;
    instructionT decoded;  // Held from T2 to the end of the instruction
    opcodeT      opcode;
    logic        knownOpcode;
    logic        lastStep;
    logic        stepDone;
    controlWordT rawWord;

    assign opcode      = decoded.addressForm.opcode;
    assign knownOpcode = instruction.addressForm.opcode inside
                         {OpLddrl, OpLddrh, OpStdr, OpSta, OpStrim};
    assign stepDone    = !memCommand.valid || done; // Memory steps wait for the APB transfer

    // ====================
    // Step sequencer
    // ====================

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            step <= StepT0;
        end else if (stepDone) begin
            step <= lastStep ? StepT0 : {step[StepCount-2:0], step[StepCount-1]};
        end
    end

    always_ff @(posedge Clock) begin
        if (step == StepT2) begin
            decoded <= instruction;
        end
    end

    // ====================
    // Control word
    // ====================

    always_comb begin
        rawWord    = '0;
        memCommand = '0;
        lastStep   = 1'b0;
        case (step)
            StepT0: begin
                memCommand.valid      = 1'b1;
                rawWord.addressSource = AddrFromPc;
                rawWord.irLowLoad     = 1'b1;
                rawWord.pcIncrement   = 1'b1;
            end
            StepT1: begin
                memCommand.valid      = 1'b1;
                rawWord.addressSource = AddrFromPc;
                rawWord.irHighLoad    = 1'b1;
                rawWord.pcIncrement   = 1'b1;
            end
            StepT2: begin
                lastStep = !knownOpcode; // Anything else is a no-op
            end
            StepT3: begin
                case (opcode)
                    OpSta: begin
                        rawWord.arLoad       = 1'b1;
                        rawWord.arLoadSource = ArSrcAddress;
                    end
                    OpStrim: begin
                        rawWord.arLoad       = 1'b1;
                        rawWord.arLoadSource = ArSrcSum;
                    end
                    OpLddrl, OpLddrh: begin
                        memCommand.valid      = 1'b1;
                        rawWord.addressSource = AddrFromAr;
                        rawWord.drLoad        = 1'b1;    // First byte clears the rest of DR
                        rawWord.arIncrement   = 1'b1;
                    end
                    OpStdr: begin
                        case (decoded.registerForm.destReg)
                            DestPc: rawWord.pcLoad = 1'b1;
                            DestSp: rawWord.spLoad = 1'b1;
                            DestAr, DestArAlt: begin
                                rawWord.arLoad       = 1'b1;
                                rawWord.arLoadSource = ArSrcDr;
                            end
                            DestR1: rawWord.regLoad[0] = 1'b1;
                            DestR2: rawWord.regLoad[1] = 1'b1;
                            DestR3: rawWord.regLoad[2] = 1'b1;
                            DestR4: rawWord.regLoad[3] = 1'b1;
                            default: rawWord.regLoad = '0;
                        endcase
                        lastStep = 1'b1;
                    end
                    default: lastStep = 1'b1;
                endcase
            end
            StepT4, StepT5, StepT6, StepT7: begin
                case (opcode)
                    OpSta, OpStrim: begin
                        memCommand.valid      = 1'b1;
                        memCommand.write      = 1'b1;
                        rawWord.addressSource = AddrFromAr;
                        rawWord.storeReg      = decoded.addressForm.regSel;
                        // T4..T7 give byte 0..3, lowest first
                        rawWord.storeByte     = {step[6] | step[7], step[5] | step[7]};
                        rawWord.arIncrement   = 1'b1;
                        lastStep              = step == StepT7;
                    end
                    OpLddrl, OpLddrh: begin
                        memCommand.valid      = 1'b1;
                        rawWord.addressSource = AddrFromAr;
                        rawWord.drLoad        = 1'b1;
                        rawWord.drShiftIn     = 1'b1;
                        rawWord.arIncrement   = 1'b1;
                        lastStep = (opcode == OpLddrl) ? step == StepT4 : step == StepT6;
                    end
                    default: lastStep = 1'b1;
                endcase
            end
            StepT8:  lastStep = 1'b1; // Not reached by the kept opcodes
            default: lastStep = 1'b1; // Illegal step, back to fetch
        endcase
    end

    // Register updates only in the cycle the step completes
    always_comb begin
        controlWord = rawWord;
        if (!stepDone) begin
            controlWord.pcLoad      = 1'b0;
            controlWord.arLoad      = 1'b0;
            controlWord.spLoad      = 1'b0;
            controlWord.drLoad      = 1'b0;
            controlWord.irLowLoad   = 1'b0;
            controlWord.irHighLoad  = 1'b0;
            controlWord.regLoad     = '0;
            controlWord.pcIncrement = 1'b0;
            controlWord.arIncrement = 1'b0;
        end
    end

    // ====================
    // Assertions
    // ====================

    stepOneHot: assert property (@(posedge Clock) disable iff (Reset)
        $onehot(step) && !step[StepCount-1])
        else $error("Step not one-hot or beyond T7: %b", step);

    commandHeld: assert property (@(posedge Clock) disable iff (Reset)
        memCommand.valid && !done |=> $stable(memCommand))
        else $error("Memory command changed before done");

endmodule

`default_nettype wire

//--- rtl/dataPath.sv
`timescale 1ns/10ps
`default_nettype none

module dataPath (
    input  logic                     Clock,
    input  logic                     Reset,
    input  datapathPkg::controlWordT controlWord,
    input  byte                      readData,
    output isaPkg::instructionT      instruction,
    output byte                      memAddress,
    output byte                      memWriteData
);
    import datapathPkg::*;

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] ar;
    logic [AddrWidth-1:0] arSum;  // STRIM effective address
    logic [AddrWidth-1:0] arNext;
    logic [ByteWidth-1:0] irLow;
    logic [ByteWidth-1:0] irHigh;
    logic [WordWidth-1:0] dr;
    logic [WordWidth-1:0] storeWord;
    logic [WordWidth-1:0] generalRegs [GeneralRegCount]; // R1..R4

    assign instruction = {irHigh, irLow};

    // ====================
    // Address side
    // ====================

    assign arSum = ar + instruction.addressForm.address; // Wraps at 256

    always_comb begin
        case (controlWord.arLoadSource)
            ArSrcAddress: arNext = instruction.addressForm.address;
            ArSrcSum:     arNext = arSum;
            ArSrcDr:      arNext = dr[AddrWidth-1:0];
            default:      arNext = ar;
        endcase
    end

    assign memAddress = (controlWord.addressSource == AddrFromAr) ? ar : pc;

    // Program counter starts at address 0
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
        end else if (controlWord.pcLoad) begin
            pc <= dr[AddrWidth-1:0];
        end else if (controlWord.pcIncrement) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (controlWord.arLoad) begin
            ar <= arNext;
        end else if (controlWord.arIncrement) begin
            ar <= ar + 1'b1;
        end
    end

    // ====================
    // Instruction and data
    // ====================

    always_ff @(posedge Clock) begin
        if (controlWord.irLowLoad) begin
            irLow <= readData;
        end
        if (controlWord.irHighLoad) begin
            irHigh <= readData;
        end
        if (controlWord.drLoad) begin
            if (controlWord.drShiftIn) begin
                dr <= {dr[WordWidth-ByteWidth-1:0], readData}; // New byte at the bottom
            end else begin
                dr <= {{(WordWidth - ByteWidth){1'b0}}, readData};
            end
        end
    end

    always_ff @(posedge Clock) begin
        for (int i = 0; i < GeneralRegCount; i++) begin
            if (controlWord.regLoad[i]) begin
                generalRegs[i] <= dr;
            end
        end
    end

    // Byte of Rx going out on a store
    assign storeWord    = generalRegs[controlWord.storeReg];
    assign memWriteData = storeWord[controlWord.storeByte * ByteWidth +: ByteWidth];

endmodule

`default_nettype wire

//--- rtl/apbRequester.sv
`timescale 1ns/10ps
`default_nettype none

module apbRequester (
    input  logic                     Clock,
    input  logic                     Reset,
    input  datapathPkg::memCommandT  memCommand,
    input  byte                      memAddress,
    input  byte                      memWriteData,
    input  datapathPkg::apbResponseT apbResponse,
    output datapathPkg::apbRequestT  apbRequest,
    output logic                     done,
    output byte                      readData
);
    typedef enum logic [1:0] {
        StateIdle,
        StateSetup,
        StateAccess
    } stateT;

    stateT state;
    stateT nextState;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= StateIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            StateIdle:   if (memCommand.valid) nextState = StateSetup;
            // Setup with no command pending falls back to idle
            StateSetup:  nextState = memCommand.valid ? StateAccess : StateIdle;
            StateAccess: if (apbResponse.pready) nextState = StateSetup;
            default:     nextState = StateIdle;
        endcase
    end

    assign apbRequest.psel    = (state == StateSetup && memCommand.valid) || state == StateAccess;
    assign apbRequest.penable = state == StateAccess;
    assign apbRequest.pwrite  = memCommand.write;
    assign apbRequest.paddr   = memAddress;   // Held by the control unit until done
    assign apbRequest.pwdata  = memWriteData;

    assign done     = state == StateAccess && apbResponse.pready; // Completion cycle only
    assign readData = apbResponse.prdata;

    enableNeedsSelect: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.penable |-> apbRequest.psel && memCommand.valid)
        else $error("PENABLE without PSEL or a pending command");

    requestHeld: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.penable && !apbResponse.pready |=> $stable(apbRequest))
        else $error("APB request changed during wait state");

endmodule

`default_nettype wire

//--- rtl/cpuSystem.sv
`timescale 1ns/10ps
`default_nettype none

module cpuSystem (
    input  logic                     Clock,
    input  logic                     Reset,
    input  datapathPkg::apbResponseT apbResponse,
    output datapathPkg::apbRequestT  apbRequest
);
    import isaPkg::*;
    import datapathPkg::*;

    controlWordT controlWord;
    memCommandT  memCommand;
    instructionT instruction;
    logic        done;
    byte         memAddress;
    byte         memWriteData;
    byte         readData;

    controlUnit control_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .instruction (instruction),
        .done        (done),
        .controlWord (controlWord),
        .memCommand  (memCommand)
    );

    dataPath dataPath_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .controlWord  (controlWord),
        .readData     (readData),
        .instruction  (instruction),
        .memAddress   (memAddress),
        .memWriteData (memWriteData)
    );

    apbRequester apb_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .memCommand   (memCommand),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .apbResponse  (apbResponse),
        .apbRequest   (apbRequest),
        .done         (done),
        .readData     (readData)
    );

endmodule

`default_nettype wire

//--- testbench/apbMemoryModel.sv
`timescale 1ns/10ps
`default_nettype none

module apbMemoryModel (
    input  logic                     Clock,
    input  datapathPkg::apbRequestT  apbRequest,
    output datapathPkg::apbResponseT apbResponse
);
    import datapathPkg::*;

    localparam logic [31:0] LfsrSeed = 32'h816e5527;

    logic [ByteWidth-1:0] mem [2**AddrWidth];          // Program and data image
    logic [31:0]          lfsr;
    logic [1:0]           waitLeft;                    // Wait states still to insert

    // Fibonacci form with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // ====================
    // Completer
    // ====================

    initial begin
        lfsr        = LfsrSeed;
        waitLeft    = 2'd0;
        apbResponse = '0;
        forever begin
            @(posedge Clock);
            #1; // Outputs move just after the edge
            apbResponse.pready = 1'b0;
            if (apbRequest.psel && !apbRequest.penable) begin
                // Setup cycle picks 0..3 wait states
                lfsr        = lfsrStep(lfsr);
                waitLeft[0] = lfsr[0];
                lfsr        = lfsrStep(lfsr);
                waitLeft[1] = lfsr[0];
            end else if (apbRequest.psel && apbRequest.penable) begin
                if (waitLeft == 2'd0) begin
                    apbResponse.pready = 1'b1;
                    if (apbRequest.pwrite) begin
                        mem[apbRequest.paddr] = apbRequest.pwdata;
                    end else begin
                        apbResponse.prdata = mem[apbRequest.paddr];
                    end
                end else begin
                    waitLeft = waitLeft - 2'd1; // Hold PREADY low one more cycle
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cpuSystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuSystemTb;
    import isaPkg::*;
    import datapathPkg::*;

    // ====================
    // Program layout
    // ====================

    localparam logic [7:0] ScratchAddr = 8'h7C;              // First STA of R1
    localparam logic [7:0] DataAddr    = ScratchAddr + 8'd4; // Where AR points after it
    localparam logic [7:0] StaAddr     = 8'h90;
    localparam logic [7:0] LowAddr     = StaAddr + 8'd4;     // AR after the STA of R2
    localparam logic [7:0] StrimOffset = 8'h60;
    localparam logic [7:0] LoopAddr    = 8'hE0;              // Target of STDR to PC

    localparam logic [7:0] DataBytes [4] = '{8'hC3, 8'h5A, 8'h96, 8'h2D};
    localparam logic [7:0] LowBytes  [2] = '{8'h7B, LoopAddr};

    localparam logic [5:0] TransferCount = 6'd40;
    localparam int         TimeoutCycles = int'(TransferCount) * 6 + 100;

    logic        Clock;
    logic        Reset;
    apbRequestT  apbRequest;
    apbResponseT apbResponse;
    logic        completing;
    logic [5:0]  seen;                         // Completed APB transfers
    logic [5:0]  expCount;
    int          cycles = 0;
    logic [7:0]  expAddr      [TransferCount];
    logic        expWrite     [TransferCount];
    logic [7:0]  expData      [TransferCount];
    logic        expCheckData [TransferCount]; // Write data known

    cpuSystem dut_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .apbResponse (apbResponse),
        .apbRequest  (apbRequest)
    );

    apbMemoryModel memory_i (
        .Clock       (Clock),
        .apbRequest  (apbRequest),
        .apbResponse (apbResponse)
    );

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic expectTransfer(input logic [7:0] addr, input logic write,
                                  input logic [7:0] data, input logic checkData);
        expAddr[expCount]      = addr;
        expWrite[expCount]     = write;
        expData[expCount]      = data;
        expCheckData[expCount] = checkData;
        expCount               = expCount + 6'd1;
    endtask

    task automatic expectFetch(input logic [7:0] pc);
        expectTransfer(pc, 1'b0, 8'h00, 1'b0);         // Low byte
        expectTransfer(pc + 8'd1, 1'b0, 8'h00, 1'b0);
    endtask

    task automatic placeInstruction(input logic [7:0] addr, input instructionT word);
        memory_i.mem[addr]        = word[7:0];
        memory_i.mem[addr + 8'd1] = word[15:8];
    endtask

    function automatic instructionT addressInstr(input opcodeT op, input logic [1:0] regSel,
                                                 input logic [7:0] address);
        instructionT word;
        word.addressForm.opcode  = op;
        word.addressForm.regSel  = regSel;
        word.addressForm.address = address;
        return word;
    endfunction

    function automatic instructionT registerInstr(input opcodeT op, input logic [2:0] dest);
        instructionT word;
        word                      = '0;
        word.registerForm.opcode  = op;
        word.registerForm.destReg = dest;
        return word;
    endfunction

    // ====================
    // Clock and reset
    // ====================

    initial Clock = 1'b0;
    always #50 Clock = ~Clock;

    initial begin
        Reset = 1'b1;
        repeat (16) @(posedge Clock);
        #1;
        Reset = 1'b0;
    end

    // ====================
    // Program and expected transfers
    // ====================

    initial begin
        logic [7:0]  ar;
        logic [31:0] dr;
        logic [31:0] storeWord;
        expCount = '0;
        for (int a = 0; a < 256; a++) begin
            memory_i.mem[a] = 8'(a) ^ 8'h5A;
        end
        placeInstruction(8'h00, addressInstr(OpSta, 2'd0, ScratchAddr)); // Leaves AR at data
        placeInstruction(8'h02, addressInstr(OpLddrh, 2'd0, 8'h00));
        placeInstruction(8'h04, registerInstr(OpStdr, DestR2));
        placeInstruction(8'h06, addressInstr(OpSta, 2'd1, StaAddr));
        placeInstruction(8'h08, addressInstr(OpLddrl, 2'd0, 8'h00));
        placeInstruction(8'h0A, registerInstr(OpStdr, DestR3));
        placeInstruction(8'h0C, registerInstr(OpStdr, DestAr));
        placeInstruction(8'h0E, addressInstr(OpStrim, 2'd2, StrimOffset));
        placeInstruction(8'h10, registerInstr(OpStdr, DestPc));
        placeInstruction(LoopAddr, registerInstr(OpStdr, DestPc)); // Jumps to itself
        for (int i = 0; i < 4; i++) begin
            memory_i.mem[DataAddr + 8'(i)] = DataBytes[i];
        end
        for (int i = 0; i < 2; i++) begin
            memory_i.mem[LowAddr + 8'(i)] = LowBytes[i];
        end

        expectFetch(8'h00);                  // STA of R1 with unchecked data
        ar = ScratchAddr;
        for (int i = 0; i < 4; i++) begin
            expectTransfer(ar, 1'b1, 8'h00, 1'b0);
            ar = ar + 8'd1;
        end
        expectFetch(8'h02);                  // LDDRH
        dr = '0;
        for (int i = 0; i < 4; i++) begin
            expectTransfer(ar, 1'b0, 8'h00, 1'b0);
            dr = {dr[23:0], DataBytes[i]};   // New byte enters at the bottom
            ar = ar + 8'd1;
        end
        expectFetch(8'h04);                  // STDR to R2
        storeWord = dr;
        expectFetch(8'h06);                  // STA of R2
        ar = StaAddr;
        for (int i = 0; i < 4; i++) begin
            expectTransfer(ar, 1'b1, storeWord[7:0], 1'b1);
            storeWord = storeWord >> 8;
            ar = ar + 8'd1;
        end
        expectFetch(8'h08);                  // LDDRL
        dr = '0;
        for (int i = 0; i < 2; i++) begin
            expectTransfer(ar, 1'b0, 8'h00, 1'b0);
            dr = {dr[23:0], LowBytes[i]};
            ar = ar + 8'd1;
        end
        expectFetch(8'h0A);                  // STDR to R3
        storeWord = dr;
        expectFetch(8'h0C);                  // STDR to AR
        ar = dr[7:0];
        expectFetch(8'h0E);                  // STRIM of R3
        ar = ar + StrimOffset;               // Wraps at 256
        for (int i = 0; i < 4; i++) begin
            expectTransfer(ar, 1'b1, storeWord[7:0], 1'b1);
            storeWord = storeWord >> 8;
            ar = ar + 8'd1;
        end
        expectFetch(8'h10);                  // STDR to PC
        expectFetch(dr[7:0]);
        expectFetch(dr[7:0]);                // Loop repeats
    end

    // ====================
    // Checks
    // ====================

    assign completing = apbRequest.psel && apbRequest.penable && apbResponse.pready;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            seen <= '0;
        end else if (completing) begin
            seen <= seen + 6'd1;
        end
    end

    transferAddress: assert property (@(posedge Clock) disable iff (Reset)
        completing && seen < TransferCount |-> apbRequest.paddr == expAddr[seen])
        else stopOnError($sformatf("FAILED paddr: transfer %0d expected 0x%h, got 0x%h",
            $sampled(seen), expAddr[$sampled(seen)], $sampled(apbRequest.paddr)));

    transferDirection: assert property (@(posedge Clock) disable iff (Reset)
        completing && seen < TransferCount |-> apbRequest.pwrite == expWrite[seen])
        else stopOnError($sformatf("FAILED pwrite: transfer %0d expected 0x%h, got 0x%h",
            $sampled(seen), expWrite[$sampled(seen)], $sampled(apbRequest.pwrite)));

    transferData: assert property (@(posedge Clock) disable iff (Reset)
        completing && seen < TransferCount && expCheckData[seen]
            |-> apbRequest.pwdata == expData[seen])
        else stopOnError($sformatf("FAILED pwdata: transfer %0d expected 0x%h, got 0x%h",
            $sampled(seen), expData[$sampled(seen)], $sampled(apbRequest.pwdata)));

    accessAfterSetup: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.penable |-> $past(apbRequest.psel && !completing))
        else stopOnError("APB access cycle without a setup cycle before it");

    setupToAccess: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.psel && !apbRequest.penable |=> apbRequest.psel && apbRequest.penable)
        else stopOnError("APB setup cycle not followed by an access cycle");

    requestHeld: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.psel && !completing
            |=> apbRequest.psel && $stable(apbRequest.paddr) && $stable(apbRequest.pwrite))
        else stopOnError("APB address or direction changed before PREADY");

    writeDataHeld: assert property (@(posedge Clock) disable iff (Reset)
        apbRequest.psel && !completing && apbRequest.pwrite && expCheckData[seen]
            |=> $stable(apbRequest.pwdata))
        else stopOnError("APB write data changed before PREADY");

    // ====================
    // End of run
    // ====================

    always @(negedge Clock) begin
        if (!Reset) begin
            cycles = cycles + 1;
            if (seen == TransferCount) begin
                $display("*** TEST PASSED ***");
                $finish;
            end else if (cycles >= TimeoutCycles) begin
                stopOnError($sformatf("Timeout after %0d cycles with %0d of %0d transfers seen",
                    cycles, seen, TransferCount));
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/apbRequester.sv
rtl/cpuSystem.sv
testbench/apbMemoryModel.sv
testbench/cpuSystemTb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --top-module cpuSystemTb -f sources.f -o cpuSystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSystemSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
exit 1
